// File: filelist.f
verilog/memStagePkg.sv
verilog/execResultIf.sv
verilog/executeUnit.sv
verilog/exMemRegister.sv
verilog/accumulatorControl.sv
verilog/memoryStage.sv
verilog/pipelineTop.sv
sim/pipelineTb.sv

// File: sim/stimulus_input.txt
# valid aluOp opA opB mulOp accEn accFunc memFunc rtData (all hex)
# then expected result flagC flagZ flagO flagN memWriteData writeL writeR
1 0 00000000 00000000 0 1 00 0 00000000 00000000 0 1 0 0 00000000 0 0
1 0 ffffffff 00000001 0 0 00 0 00000000 00000000 1 1 0 0 00000000 0 0
1 0 7fffffff 00000001 0 0 00 0 00000000 80000000 0 0 1 1 00000000 0 0
1 1 12345678 12345678 0 0 00 1 12345680 00000000 0 1 0 0 ffffff80 0 0
1 1 00000003 00000005 0 0 00 2 12348001 fffffffe 1 0 0 1 ffff8001 0 0
1 1 80000000 00000001 0 0 00 3 deadbeef 7fffffff 0 0 1 0 deadbeef 0 0
1 2 f0f0f0f0 ff00ff00 0 0 00 4 cafef00d f000f000 0 0 0 1 cafef00d 1 0
1 3 0000ffff 80000000 0 0 00 5 0badc0de 8000ffff 0 0 0 1 0badc0de 0 1
1 4 a5a5a5a5 a5a5a5a5 0 0 00 0 55aa55aa 00000000 0 1 0 0 55aa55aa 0 0
1 5 12345678 00000024 0 0 00 0 00000000 23456780 0 0 0 0 00000000 0 0
0 0 00000000 00000000 0 0 00 0 00000000 00000000 0 0 0 0 00000000 0 0
1 2 fffffffe 00000003 1 0 00 1 abcdef7f fffffffa 0 0 0 0 0000007f 0 0
1 2 ffffffff ffffffff 1 0 00 2 87657fff 00000001 0 0 0 1 00007fff 0 0
1 0 00010000 00030000 1 1 01 0 00000000 00000000 0 0 0 0 00000000 0 0
1 0 00010000 00010000 1 1 02 0 00000000 00000000 0 0 0 0 00000000 0 0
1 0 00020000 00020000 1 1 03 0 00000000 00000000 0 1 0 0 00000000 0 0
0 0 00000000 00000000 0 0 00 0 00000000 00000000 0 0 0 0 00000000 0 0
1 0 ffffffff 00000005 1 1 02 0 00000000 fffffffb 0 0 0 1 00000000 0 0
1 0 00000004 00000003 0 1 02 0 00000000 00000002 1 0 0 0 00000000 0 0
1 0 00000002 00000003 1 1 03 0 00000000 fffffffc 1 0 0 1 00000000 0 0
1 0 00000000 00000000 0 1 00 0 00000000 fffffffc 0 0 0 1 00000000 0 0

// File: sim/pipelineTb.sv
`timescale 1ns/1ps

module pipelineTb;

    // One expected response, as listed in the data file.
    typedef struct packed {
        logic [31:0]         result;
        memStagePkg::flags_t flags;
        logic [31:0]         memData;
        logic                writeL;
        logic                writeR;
    } expect_t;

    // One input line.
    typedef struct packed {
        logic        valid;
        logic [2:0]  aluOp;
        logic [31:0] opA;
        logic [31:0] opB;
        logic        mulOp;
        logic        accEn;
        logic [5:0]  accFunc;
        logic [2:0]  memFunc;
        logic [31:0] rtData;
        expect_t     exp;
    } vector_t;

    logic                  Clock;
    logic                  rst;
    logic                  inValid;
    memStagePkg::aluOp_t   aluOp;
    logic [31:0]           opA;
    logic [31:0]           opB;
    logic                  mulOp;
    logic                  accEn;
    memStagePkg::accFunc_t accFunc;
    memStagePkg::memFunc_t memFunc;
    logic [31:0]           rtData;
    logic                  outValid;
    logic [31:0]           result;
    logic                  flagC;
    logic                  flagZ;
    logic                  flagO;
    logic                  flagN;
    logic [31:0]           memWriteData;
    logic                  writeL;
    logic                  writeR;

    vector_t vectors[$];     // Whole file, in order.
    expect_t expQ[$];        // Instructions in flight.
    logic    expectValid;    // Valid input driven last cycle.
    int      cycleCount = 0;
    int      timeoutLimit = 0;

    pipelineTop pipelineTop_i (.*);

    initial
    begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock; // 20 ns period.
    end

    // ------------------------------------------------------------------------
    // Failure paths
    // ------------------------------------------------------------------------

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compareWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            stopRun($sformatf("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic compareFlags(input memStagePkg::flags_t exp, input memStagePkg::flags_t act);
        if (act !== exp)
            stopRun($sformatf("FAILED at %0t ns: flags (CZON) expected %b, got %b",
                              $time, exp, act));
    endtask

    task automatic compareStrobe(input string name, input logic exp, input logic act);
        if (act !== exp)
            stopRun($sformatf("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act));
    endtask

    // Hangs are caught by a budget based on vector count.
    always @(posedge Clock)
    begin
        cycleCount = cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit)
            stopRun("Timeout. The run went past its cycle limit.");
    end

    // ------------------------------------------------------------------------
    // Stimulus and checking
    // ------------------------------------------------------------------------

    task automatic readVectors();
        int          fd;
        int          fieldCount;
        string       line;
        logic [31:0] f [17];
        vector_t     v;
        fd = $fopen("sim/stimulus_input.txt", "r");
        if (fd == 0)
            stopRun("Could not open sim/stimulus_input.txt for reading.");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.substr(0, 0) != "#") // Skip comments and blanks.
            begin
                fieldCount = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                     f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                if (fieldCount != 17)
                    stopRun($sformatf("Malformed line in stimulus file: %s", line));
                v = '{f[0][0], f[1][2:0], f[2], f[3], f[4][0], f[5][0], f[6][5:0], f[7][2:0],
                      f[8], '{f[9], '{f[10][0], f[11][0], f[12][0], f[13][0]},
                              f[14], f[15][0], f[16][0]}};
                vectors.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    task automatic applyVector(input vector_t v);
        inValid = v.valid;
        aluOp   = memStagePkg::aluOp_t'(v.aluOp);
        opA     = v.opA;
        opB     = v.opB;
        mulOp   = v.mulOp;
        accEn   = v.accEn;
        accFunc = memStagePkg::accFunc_t'(v.accFunc);
        memFunc = memStagePkg::memFunc_t'(v.memFunc);
        rtData  = v.rtData;
        if (v.valid)
            expQ.push_back(v.exp); // Due one cycle later.
        expectValid = v.valid;
    endtask

    task automatic checkOutputs();
        expect_t             exp;
        memStagePkg::flags_t act;
        act.carry    = flagC;
        act.zero     = flagZ;
        act.overflow = flagO;
        act.negative = flagN;
        if (outValid === 1'b1)
        begin
            if (expQ.size() == 0)
                stopRun("outValid went high with no instruction pending.");
            else
            begin
                exp = expQ.pop_front();
                compareWord("result", exp.result, result);
                compareFlags(exp.flags, act);
                compareWord("memWriteData", exp.memData, memWriteData);
                compareStrobe("writeL", exp.writeL, writeL);
                compareStrobe("writeR", exp.writeR, writeR);
            end
        end
        else if (expectValid)
            stopRun("outValid stayed low one cycle after a valid input.");
        else
        begin
            compareStrobe("writeL", 1'b0, writeL); // Strobes quiet when idle.
            compareStrobe("writeR", 1'b0, writeR);
        end
    endtask

    initial
    begin
        vector_t idle;
        rst = 1'b1;
        applyVector('0);
        readVectors();
        timeoutLimit = 8 + 2 * vectors.size() + 20;
        repeat (8) @(posedge Clock);
        @(negedge Clock);
        rst = 1'b0;
        foreach (vectors[i])
        begin
            checkOutputs();
            applyVector(vectors[i]);
            @(negedge Clock);
        end
        checkOutputs(); // Last instruction.
        idle = '0;
        idle.memFunc = memStagePkg::memWordLeft; // Unaligned format, no valid.
        applyVector(idle);
        @(negedge Clock);
        checkOutputs();
        idle.memFunc = memStagePkg::memWordRight;
        applyVector(idle);
        @(negedge Clock);
        checkOutputs();
        if (expQ.size() != 0)
            stopRun("Some instructions never produced a result.");
        else
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: verilog/pipelineTop.sv
`timescale 1ns/1ps

module pipelineTop (
    input  logic                  Clock,
    input  logic                  rst,
    input  logic                  inValid,
    input  memStagePkg::aluOp_t   aluOp,
    input  logic [31:0]           opA,
    input  logic [31:0]           opB,
    input  logic                  mulOp,
    input  logic                  accEn,
    input  memStagePkg::accFunc_t accFunc,
    input  memStagePkg::memFunc_t memFunc,
    input  logic [31:0]           rtData,
    output logic                  outValid,
    output logic [31:0]           result,
    output logic                  flagC,
    output logic                  flagZ,
    output logic                  flagO,
    output logic                  flagN,
    output logic [31:0]           memWriteData,
    output logic                  writeL,
    output logic                  writeR
);

    memStagePkg::flags_t flags;

    // --------------------------------------------------------------------------
    // Stage links
    // --------------------------------------------------------------------------

    execResultIf exRes ();  // Execute to register.
    execResultIf memRes (); // Register to memory stage.

    executeUnit executeUnit_i (
        .inValid (inValid),
        .aluOp   (aluOp),
        .opA     (opA),
        .opB     (opB),
        .mulOp   (mulOp),
        .accEn   (accEn),
        .accFunc (accFunc),
        .memFunc (memFunc),
        .rtData  (rtData),
        .res     (exRes.producer)
    );

    exMemRegister exMemRegister_i (
        .Clock  (Clock),
        .rst    (rst),
        .inRes  (exRes.consumer),
        .outRes (memRes.producer)
    );

    memoryStage memoryStage_i (
        .Clock        (Clock),
        .rst          (rst),
        .res          (memRes.consumer),
        .outValid     (outValid),
        .result       (result),
        .flags        (flags),
        .memWriteData (memWriteData),
        .writeL       (writeL),
        .writeR       (writeR)
    );

    // Flags leave as single bits.
    assign flagC = flags.carry;
    assign flagZ = flags.zero;
    assign flagO = flags.overflow;
    assign flagN = flags.negative;

endmodule

// File: verilog/memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
    input  logic                Clock,
    input  logic                rst,
    execResultIf.consumer       res,          // Held instruction.
    output logic                outValid,
    output logic [31:0]         result,
    output memStagePkg::flags_t flags,
    output logic [31:0]         memWriteData, // Formatted store data.
    output logic                writeL,
    output logic                writeR
);

    memStagePkg::product_u sel;       // Chosen 64-bit input.
    logic [31:0]           accOut;
    memStagePkg::flags_t   accFlags;

    // Product, or ALU result zero-extended.
    always_comb
    begin
        if (res.mulOp)
            sel = res.product;
        else
        begin
            sel.words.high = 32'd0;
            sel.words.low  = res.aluResult;
        end
    end

    accumulatorControl accumulatorControl_i (
        .Clock    (Clock),
        .rst      (rst),
        .update   (res.valid && res.accEn), // Real instructions only.
        .func     (res.accFunc),
        .in       (sel),
        .out      (accOut),
        .accFlags (accFlags)
    );

    assign outValid = res.valid;
    assign result   = res.accEn ? accOut : sel.words.low;
    assign flags    = res.accEn ? accFlags : res.aluFlags; // ALU flags on plain mul.

    // --------------------------------------------------------------------------
    // Store formatting
    // --------------------------------------------------------------------------

    always_comb
    begin
        writeL = res.valid && (res.memFunc == memStagePkg::memWordLeft);
        writeR = res.valid && (res.memFunc == memStagePkg::memWordRight);
        case (res.memFunc)
            memStagePkg::memByteSigned: memWriteData = {{24{res.rtData[7]}}, res.rtData[7:0]};
            memStagePkg::memHalfSigned: memWriteData = {{16{res.rtData[15]}}, res.rtData[15:0]};
            default:                    memWriteData = res.rtData; // Word forms.
        endcase
    end

    // A valid instruction stores in a known format.
    property knownMemFunc;
        @(posedge Clock) disable iff (rst)
            res.valid |-> (res.memFunc inside {
                memStagePkg::memNone, memStagePkg::memByteSigned, memStagePkg::memHalfSigned,
                memStagePkg::memWord, memStagePkg::memWordLeft, memStagePkg::memWordRight});
    endproperty

    memFuncDefined: assert property (knownMemFunc)
        else $error("memoryStage: undefined memFunc %0d", res.memFunc);

endmodule

// File: verilog/accumulatorControl.sv
`timescale 1ns/1ps

module accumulatorControl (
    input  logic                  Clock,
    input  logic                  rst,
    input  logic                  update,   // Write next value.
    input  memStagePkg::accFunc_t func,
    input  memStagePkg::product_u in,
    output logic [31:0]           out,      // Low word of next value.
    output memStagePkg::flags_t   accFlags
);

    logic signed [63:0] acc;     // Running 64-bit total.
    logic [63:0]        accNext;
    logic [64:0]        wide;    // Sum with carry in bit 64.
    logic               carry;
    logic               overflow;

    // --------------------------------------------------------------------------
    // Next value
    // --------------------------------------------------------------------------

    always_comb
    begin
        wide     = '0;
        accNext  = acc;  // Hold by default.
        carry    = 1'b0;
        overflow = 1'b0;
        case (func)
            memStagePkg::accLoad:
                accNext = in.full;
            memStagePkg::accMadd:
            begin
                wide     = {1'b0, acc} + {1'b0, in.full};
                accNext  = wide[63:0];
                carry    = wide[64];
                // Operands agree in sign, sum does not.
                overflow = (acc[63] == in.full[63]) && (accNext[63] != acc[63]);
            end
            memStagePkg::accMsub:
            begin
                wide     = {1'b0, acc} - {1'b0, in.full};
                accNext  = wide[63:0];
                carry    = wide[64]; // Borrow out.
                overflow = (acc[63] != in.full[63]) && (accNext[63] != acc[63]);
            end
            default:
                accNext = acc;
        endcase
    end

    assign out = accNext[31:0];

    // Flags follow the whole 64-bit value.
    always_comb
    begin
        accFlags.carry    = carry;
        accFlags.overflow = overflow;
        accFlags.zero     = (accNext == 64'd0);
        accFlags.negative = accNext[63];
    end

    // --------------------------------------------------------------------------
    // Register
    // --------------------------------------------------------------------------

    always_ff @(posedge Clock)
    begin
        if (rst)
            acc <= '0;
        else if (update)
            acc <= accNext; // Seen by the next accumulating instruction.
    end

    // Only known functions may reach the register.
    property knownFuncOnUpdate;
        @(posedge Clock) disable iff (rst)
            update |-> (func inside {memStagePkg::accHold, memStagePkg::accLoad,
                                     memStagePkg::accMadd, memStagePkg::accMsub});
    endproperty

    accFuncDefined: assert property (knownFuncOnUpdate)
        else $error("accumulatorControl: undefined func %0d", func);

endmodule

// File: verilog/exMemRegister.sv
`timescale 1ns/1ps

module exMemRegister (
    input  logic          Clock,
    input  logic          rst,
    execResultIf.consumer inRes,  // From execute.
    execResultIf.producer outRes  // To memory stage.
);

    // --------------------------------------------------------------------------
    // Control fields
    // --------------------------------------------------------------------------

    // Cleared so nothing stores or accumulates out of reset.
    always_ff @(posedge Clock)
    begin
        if (rst)
        begin
            outRes.valid   <= 1'b0;
            outRes.accEn   <= 1'b0;
            outRes.memFunc <= memStagePkg::memNone;
        end
        else
        begin
            outRes.valid   <= inRes.valid;
            outRes.accEn   <= inRes.accEn;
            outRes.memFunc <= inRes.memFunc;
        end
    end

    // --------------------------------------------------------------------------
    // Payload
    // --------------------------------------------------------------------------

    always_ff @(posedge Clock)
    begin
        outRes.aluResult <= inRes.aluResult;
        outRes.aluFlags  <= inRes.aluFlags;
        outRes.product   <= inRes.product;
        outRes.mulOp     <= inRes.mulOp;
        outRes.accFunc   <= inRes.accFunc; // Only acted on with accEn.
        outRes.rtData    <= inRes.rtData;
    end

    // Valid and the control fields it qualifies are known on entry.
    property knownControl;
        @(posedge Clock) disable iff (rst)
            !$isunknown(inRes.valid) &&
            (!inRes.valid || !$isunknown({inRes.accEn, inRes.mulOp, inRes.memFunc}));
    endproperty

    controlKnown: assert property (knownControl)
        else $error("exMemRegister: unknown control field on entry");

endmodule

// File: verilog/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
    input  logic                  inValid,
    input  memStagePkg::aluOp_t   aluOp,
    input  logic [31:0]           opA,
    input  logic [31:0]           opB,
    input  logic                  mulOp,
    input  logic                  accEn,
    input  memStagePkg::accFunc_t accFunc,
    input  memStagePkg::memFunc_t memFunc,
    input  logic [31:0]           rtData,
    execResultIf.producer         res
);

    logic [32:0] sum;       // Add/sub with carry out.
    logic [31:0] aluOut;
    logic        carry;
    logic        overflow;

    // --------------------------------------------------------------------------
    // ALU
    // --------------------------------------------------------------------------

    always_comb
    begin
        sum      = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (aluOp)
            memStagePkg::aluAdd:
            begin
                sum      = {1'b0, opA} + {1'b0, opB};
                aluOut   = sum[31:0];
                carry    = sum[32];
                // Same signs in, other sign out.
                overflow = (opA[31] == opB[31]) && (aluOut[31] != opA[31]);
            end
            memStagePkg::aluSub:
            begin
                sum      = {1'b0, opA} - {1'b0, opB};
                aluOut   = sum[31:0];
                carry    = sum[32]; // Borrow.
                overflow = (opA[31] != opB[31]) && (aluOut[31] != opA[31]);
            end
            memStagePkg::aluAnd: aluOut = opA & opB;
            memStagePkg::aluOr:  aluOut = opA | opB;
            memStagePkg::aluXor: aluOut = opA ^ opB;
            memStagePkg::aluSll: aluOut = opA << opB[4:0]; // Shamt in low bits.
            default:             aluOut = '0;
        endcase
    end

    always_comb
    begin
        res.aluResult         = aluOut;
        res.aluFlags.carry    = carry;
        res.aluFlags.overflow = overflow;
        res.aluFlags.zero     = (aluOut == 32'd0);
        res.aluFlags.negative = aluOut[31];
    end

    // --------------------------------------------------------------------------
    // Multiplier
    // --------------------------------------------------------------------------

    // Both operands signed, full 64-bit product.
    assign res.product.full = $signed(opA) * $signed(opB);

    // Control fields ride along unchanged.
    assign res.valid   = inValid;
    assign res.mulOp   = mulOp;
    assign res.accEn   = accEn;
    assign res.accFunc = accFunc;
    assign res.memFunc = memFunc;
    assign res.rtData  = rtData;

    // A valid instruction never carries an unused opcode.
    aluOpDefined: assert final (
        !inValid || (aluOp inside {memStagePkg::aluAdd, memStagePkg::aluSub,
                                   memStagePkg::aluAnd, memStagePkg::aluOr,
                                   memStagePkg::aluXor, memStagePkg::aluSll}))
        else $error("executeUnit: undefined aluOp %0d", aluOp);

endmodule

// File: verilog/execResultIf.sv
`timescale 1ns/1ps

// Results of one instruction leaving execute.
interface execResultIf;

    logic                  valid;     // Instruction present.
    logic [31:0]           aluResult;
    memStagePkg::flags_t   aluFlags;
    memStagePkg::product_u product;   // Signed 64-bit product.
    logic                  mulOp;     // Select product over ALU.
    logic                  accEn;     // Route through accumulator.
    memStagePkg::accFunc_t accFunc;
    memStagePkg::memFunc_t memFunc;
    logic [31:0]           rtData;    // Raw store data.

    // Side that fills the bundle.
    modport producer (
        output valid, aluResult, aluFlags, product,
        output mulOp, accEn, accFunc, memFunc, rtData
    );

    // Side that uses it.
    modport consumer (
        input valid, aluResult, aluFlags, product,
        input mulOp, accEn, accFunc, memFunc, rtData
    );

endinterface

// File: verilog/memStagePkg.sv
package memStagePkg;

    // --------------------------------------------------------------------------
    // Instruction field encodings
    // --------------------------------------------------------------------------

    // ALU operation select.
    typedef enum logic [2:0] {
        aluAdd = 3'd0, // Add, carry and overflow valid.
        aluSub = 3'd1, // Subtract, carry is borrow.
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSll = 3'd5  // Shift opA left by opB[4:0].
    } aluOp_t;

    // Accumulator function, taken from the funct field.
    typedef enum logic [5:0] {
        accHold = 6'h00, // Keep value, still report it.
        accLoad = 6'h01, // Overwrite with input.
        accMadd = 6'h02, // Accumulate.
        accMsub = 6'h03  // Deduct.
    } accFunc_t;

    // Store data format.
    typedef enum logic [2:0] {
        memNone       = 3'd0,
        memByteSigned = 3'd1, // Sign-extended byte.
        memHalfSigned = 3'd2, // Sign-extended half.
        memWord       = 3'd3,
        memWordLeft   = 3'd4, // Unaligned store, left part.
        memWordRight  = 3'd5  // Unaligned store, right part.
    } memFunc_t;

    // --------------------------------------------------------------------------
    // Result types
    // --------------------------------------------------------------------------

    // Condition flags, shared by ALU and accumulator.
    typedef struct packed {
        logic carry;
        logic zero;
        logic overflow;
        logic negative;
    } flags_t;

    // Two halves of a 64-bit value.
    typedef struct packed {
        logic [31:0] high;
        logic [31:0] low;
    } wordPair_t;

    // Multiplier product.
    // Seen whole by the accumulator, as words by result select.
    typedef union packed {
        logic signed [63:0] full;
        wordPair_t          words;
    } product_u;

endpackage
